/* common/sram_pkg.sv */
package sram_pkg;

  // ==================================================================
  // Geometry
  // ==================================================================

  localparam int ADDR_WIDTH = 4;  // 16 words
  localparam int DATA_WIDTH = 16;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;  // One strobe per byte lane
  localparam int DEPTH      = 1 << ADDR_WIDTH;

  // ==================================================================
  // Response queue
  // ==================================================================

  localparam int RESP_FIFO_AW = 2;  // 4 entries
  localparam int RESP_LIMIT   = 2;  // Stop accepting at half full

  // ==================================================================
  // Command and read word
  // ==================================================================

  // Command payload, held stable by the sender while cmd_ready is low
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic                  wr_en;    // 1 = write, 0 = read
    logic [DATA_WIDTH-1:0] wr_data;
    logic [STRB_WIDTH-1:0] wr_strb;  // Ignored on reads
  } sram_cmd_t;

  // Word leaving the array toward the response queue
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
  } sram_rd_t;

endpackage

/* design/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
  parameter int AW = sram_pkg::RESP_FIFO_AW
) (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               push,
  input  sram_pkg::sram_rd_t wdata,

  input  logic               pop,
  output sram_pkg::sram_rd_t rdata,

  output logic               empty,
  output logic [AW:0]        count
);

  sram_pkg::sram_rd_t mem [1 << AW];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          full;
  logic          do_push;
  logic          do_pop;

  assign full    = count[AW];  // Only set when count == 2**AW
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // ==================================================================
  // Storage
  // ==================================================================

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  assign rdata = mem[rd_ptr];  // Head entry

  // ==================================================================
  // Pointers and occupancy
  // ==================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push and pop together
      endcase
    end
  end

endmodule

/* design/sram_array.sv */
`timescale 1ns/1ps

module sram_array (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                acc_en,
  input  sram_pkg::sram_cmd_t cmd,

  output sram_pkg::sram_rd_t  rd
);

  logic [sram_pkg::DATA_WIDTH-1:0] mem [sram_pkg::DEPTH];

  // ==================================================================
  // Reset pattern and byte-strobe write
  // ==================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // Each word starts out holding its own address
      for (int i = 0; i < sram_pkg::DEPTH; i++) begin
        mem[i] <= sram_pkg::DATA_WIDTH'(i);
      end
    end else if (acc_en && cmd.wr_en) begin
      for (int b = 0; b < sram_pkg::STRB_WIDTH; b++) begin
        if (cmd.wr_strb[b]) begin
          mem[cmd.addr][b*8 +: 8] <= cmd.wr_data[b*8 +: 8];  // Lane b only
        end
      end
    end
  end

  // ==================================================================
  // Registered read
  // ==================================================================

  // One cycle of latency, the word is valid after the accepting edge.
  // The register holds its value until the next read so the control
  // block can push it one edge later.
  always_ff @(posedge clk) begin
    if (acc_en && !cmd.wr_en) begin
      rd.data <= mem[cmd.addr];
    end
  end

endmodule

/* design/sram_ctrl.sv */
`timescale 1ns/1ps

module sram_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,

  // Command side
  input  logic                          cmd_valid,
  input  logic                          cmd_wr_en,
  output logic                          cmd_ready,

  // Array
  output logic                          acc_en,

  // Response queue
  output logic                          fifo_push,
  output logic                          fifo_pop,
  input  logic [sram_pkg::RESP_FIFO_AW:0] fifo_count,
  input  logic                          fifo_empty,

  // Response side
  output logic                          resp_valid,
  input  logic                          resp_ready
);

  logic                          rd_pending;  // Read latched, push due next edge
  logic [sram_pkg::RESP_FIFO_AW:0] occupancy;

  // ==================================================================
  // Command acceptance
  // ==================================================================

  // Count the read in flight as already occupying a queue slot
  assign occupancy = fifo_count + (sram_pkg::RESP_FIFO_AW + 1)'(rd_pending);
  assign cmd_ready = (occupancy < sram_pkg::RESP_LIMIT);
  assign acc_en    = cmd_valid && cmd_ready;  // Writes and reads alike

  // ==================================================================
  // Read in flight
  // ==================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= acc_en && !cmd_wr_en;  // Lasts exactly one cycle
    end
  end

  assign fifo_push = rd_pending;  // Array read register is valid now

  // ==================================================================
  // Response handshake
  // ==================================================================

  assign resp_valid = !fifo_empty;
  assign fifo_pop   = resp_valid && resp_ready;

endmodule

/* design/sram_subsys_top.sv */
`timescale 1ns/1ps

module sram_subsys_top (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                cmd_valid,
  input  sram_pkg::sram_cmd_t cmd,
  output logic                cmd_ready,

  output logic                resp_valid,
  output sram_pkg::sram_rd_t  resp,
  input  logic                resp_ready
);

  logic                            acc_en;
  logic                            fifo_push;
  logic                            fifo_pop;
  logic                            fifo_empty;
  logic [sram_pkg::RESP_FIFO_AW:0] fifo_count;
  sram_pkg::sram_rd_t              rd_word;  // Array read register to queue

  // ==================================================================
  // Control
  // ==================================================================

  sram_ctrl i_sram_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_wr_en  (cmd.wr_en),
    .cmd_ready  (cmd_ready),
    .acc_en     (acc_en),
    .fifo_push  (fifo_push),
    .fifo_pop   (fifo_pop),
    .fifo_count (fifo_count),
    .fifo_empty (fifo_empty),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
  );

  // ==================================================================
  // Storage and response queue
  // ==================================================================

  sram_array i_sram_array (
    .clk    (clk),
    .rst_n  (rst_n),
    .acc_en (acc_en),
    .cmd    (cmd),
    .rd     (rd_word)
  );

  sync_fifo #(
    .AW (sram_pkg::RESP_FIFO_AW)
  ) i_sync_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (fifo_push),
    .wdata (rd_word),
    .pop   (fifo_pop),
    .rdata (resp),
    .empty (fifo_empty),
    .count (fifo_count)
  );

endmodule

/* tb/tb_sram_subsys.sv */
`timescale 1ns/1ps

module tb_sram_subsys;

  localparam int AW           = sram_pkg::ADDR_WIDTH;
  localparam int DW           = sram_pkg::DATA_WIDTH;
  localparam int SW           = sram_pkg::STRB_WIDTH;
  localparam int ACCEPT_LIMIT = 50;   // Cycles a command may wait for cmd_ready
  localparam int DRAIN_LIMIT  = 100;

  logic                clk = 1'b0;
  logic                rst_n;
  logic                cmd_valid;
  sram_pkg::sram_cmd_t cmd;
  logic                cmd_ready;
  logic                resp_valid;
  sram_pkg::sram_rd_t  resp;
  logic                resp_ready;

  logic [DW-1:0] shadow [sram_pkg::DEPTH];
  logic [DW-1:0] exp_q [$];            // Expected responses in command order
  logic [DW-1:0] exp_head;
  int            exp_cnt;              // Reads accepted and not yet returned
  logic          rd_empty_d1;          // Read accepted with nothing outstanding
  logic          rd_empty_d2;
  int            rr_mode;              // 0 low, 1 high, 2 random
  int            err_cnt;
  int            err_base;
  int            test_cnt;

  sram_subsys_top i_sram_subsys_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_ready  (cmd_ready),
    .resp_valid (resp_valid),
    .resp       (resp),
    .resp_ready (resp_ready)
  );

  always #4 clk = ~clk;

  always @(negedge clk) begin
    case (rr_mode)
      0:       resp_ready = 1'b0;
      1:       resp_ready = 1'b1;
      default: resp_ready = 1'($urandom_range(0, 1));
    endcase
  end

  // ==================================================================
  // Reference model
  // ==================================================================

  always @(posedge clk) begin
    logic was_empty;
    was_empty = (exp_q.size() == 0);
    if (!rst_n) begin
      exp_q.delete();
      for (int i = 0; i < sram_pkg::DEPTH; i++) begin
        shadow[i] = DW'(i);  // Word holds its own address
      end
      rd_empty_d1 = 1'b0;
      rd_empty_d2 = 1'b0;
    end else begin
      rd_empty_d2 = rd_empty_d1;
      rd_empty_d1 = 1'b0;
      if (resp_valid && resp_ready && !was_empty) begin
        void'(exp_q.pop_front());
      end
      if (cmd_valid && cmd_ready) begin
        if (cmd.wr_en) begin
          for (int b = 0; b < SW; b++) begin
            if (cmd.wr_strb[b]) begin
              shadow[cmd.addr][b*8 +: 8] = cmd.wr_data[b*8 +: 8];
            end
          end
        end else begin
          exp_q.push_back(shadow[cmd.addr]);
          rd_empty_d1 = was_empty;
        end
      end
    end
    exp_cnt  = exp_q.size();
    exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
  end

  // ==================================================================
  // Checks
  // ==================================================================

  a_reset_state: assert property (@(posedge clk) $rose(rst_n) |-> (cmd_ready && !resp_valid))
    else begin
      $display("FAILED {cmd_ready,resp_valid}: expected 2, got %h",
               {$sampled(cmd_ready), $sampled(resp_valid)});
      err_cnt++;
    end

  a_resp_data: assert property (@(posedge clk) disable iff (!rst_n)
    (resp_valid && resp_ready) |-> (resp.data == exp_head))
    else begin
      $display("FAILED resp.data: expected %h, got %h", $sampled(exp_head), $sampled(resp.data));
      err_cnt++;
    end

  a_no_extra_resp: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid |-> (exp_cnt != 0))
    else begin
      $display("Response presented with no read outstanding");
      err_cnt++;
    end

  a_cmd_ready: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_ready == (exp_cnt < sram_pkg::RESP_LIMIT))
    else begin
      $display("FAILED cmd_ready: expected %h, got %h",
               $sampled(exp_cnt) < sram_pkg::RESP_LIMIT, $sampled(cmd_ready));
      err_cnt++;
    end

  a_lat_quiet: assert property (@(posedge clk) disable iff (!rst_n) rd_empty_d1 |-> !resp_valid)
    else begin
      $display("FAILED resp_valid: expected 0, got %h", $sampled(resp_valid));
      err_cnt++;
    end

  a_lat_rise: assert property (@(posedge clk) disable iff (!rst_n) rd_empty_d2 |-> resp_valid)
    else begin
      $display("FAILED resp_valid: expected 1, got %h", $sampled(resp_valid));
      err_cnt++;
    end

  // ==================================================================
  // Stimulus tasks, all entered and left on a falling edge
  // ==================================================================

  task automatic send_cmd(input logic wr, input logic [AW-1:0] addr,
                          input logic [DW-1:0] data, input logic [SW-1:0] strb);
    int waited;
    waited        = 0;
    cmd_valid     = 1'b1;
    cmd.addr      = addr;
    cmd.wr_en     = wr;
    cmd.wr_data   = data;
    cmd.wr_strb   = strb;
    while (!cmd_ready && waited < ACCEPT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!cmd_ready) begin
      $display("Timeout: command to address %h was never accepted", addr);
      err_cnt++;
      cmd_valid = 1'b0;
    end else begin
      @(negedge clk);  // Transfer happens on the rising edge in between
    end
  endtask

  task automatic drain_responses();
    int waited;
    waited    = 0;
    cmd_valid = 1'b0;
    rr_mode   = 1;
    while ((exp_cnt != 0 || resp_valid) && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_cnt != 0 || resp_valid) begin
      $display("Timeout: %0d responses still outstanding", exp_cnt);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("Test %s finished with %0d errors", name, err_cnt - err_base);
    test_cnt++;
    err_base = err_cnt;
  endtask

  // ==================================================================
  // Test sequence
  // ==================================================================

  initial begin
    logic [AW-1:0] addr;
    logic [DW-1:0] data;
    void'($urandom(32'h1247e2a7));
    rst_n = 1'b0;
    cmd_valid = 1'b0;
    cmd = '0;
    resp_ready = 1'b0;
    rr_mode = 1;
    err_cnt = 0;
    err_base = 0;
    test_cnt = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int a = 0; a < sram_pkg::DEPTH; a++) begin
      send_cmd(1'b0, AW'(a), '0, '0);
    end
    drain_responses();
    finish_test("reset_state");

    for (int n = 0; n < 12; n++) begin
      addr = AW'($urandom_range(0, sram_pkg::DEPTH - 1));
      data = DW'($urandom());
      send_cmd(1'b1, addr, data, '1);
      send_cmd(1'b0, addr, '0, '0);  // Back to back with the write
    end
    drain_responses();
    finish_test("full_word_write");

    for (int n = 0; n < 12; n++) begin
      addr = AW'($urandom_range(0, sram_pkg::DEPTH - 1));
      data = DW'($urandom());
      send_cmd(1'b1, addr, data, SW'(1) << $urandom_range(0, SW - 1));
      send_cmd(1'b0, addr, '0, '0);
    end
    drain_responses();
    finish_test("byte_strobe");

    for (int n = 0; n < 4; n++) begin
      send_cmd(1'b0, AW'($urandom_range(0, sram_pkg::DEPTH - 1)), '0, '0);
      drain_responses();
    end
    finish_test("read_latency");

    rr_mode = 0;
    @(negedge clk);
    send_cmd(1'b0, 4'h3, '0, '0);
    send_cmd(1'b0, 4'h7, '0, '0);
    fork
      send_cmd(1'b0, 4'hc, '0, '0);  // Stalls until the queue drains
      begin
        repeat (6) @(negedge clk);
        rr_mode = 1;
      end
    join
    rr_mode = 2;
    for (int n = 0; n < 40; n++) begin
      send_cmd(1'($urandom_range(0, 1)), AW'($urandom_range(0, sram_pkg::DEPTH - 1)),
               DW'($urandom()), SW'($urandom_range(0, (1 << SW) - 1)));
    end
    drain_responses();
    finish_test("backpressure_order");

    $display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* vlog.f */
common/sram_pkg.sv
design/sync_fifo.sv
design/sram_array.sv
design/sram_ctrl.sv
design/sram_subsys_top.sv
tb/tb_sram_subsys.sv

/* Makefile */
# Verilator build for the scratch memory testbench

VERILATOR ?= verilator
TOP       ?= tb_sram_subsys
SEED_ARGS ?=
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal

FILELIST  := vlog.f
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) $(SEED_ARGS) 2>&1 | tee $(LOG)

check: run
	@if grep -q "Done: errors found" $(LOG); then \
		echo "Simulation reported errors"; exit 1; \
	fi
	@if ! grep -q "Done: no errors" $(LOG); then \
		echo "Simulation did not complete"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
